// File: alu/alu_result_stage.sv
// result stage of the SIMD ALU
// bitwise logic ops and the result mux by operator
// output register with valid/ready on both sides

`timescale 1ns/1ps

module alu_result_stage import alu_pkg::*; (
  input  logic      clk,
  input  logic      rst_i,
  alu_op_if.unit    op_if,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  input  alu_word_u sum_i,
  input  alu_word_u shift_i,
  input  alu_word_u minmax_i,
  input  logic      cmp_flag_i,
  output alu_word_u result_o,
  output logic      comparison_result_o,
  output logic      out_valid_o,
  input  logic      out_ready_i
);

  alu_word_u result_next;
  logic      in_fire;
  logic      out_fire;

  ////////////////////////////////////////
  // result mux
  ////////////////////////////////////////

  always_comb
  begin
    case (op_if.operator)
      ALU_AND:  result_next = op_if.operand_a.w & op_if.operand_b.w;
      ALU_OR:   result_next = op_if.operand_a.w | op_if.operand_b.w;
      ALU_XOR:  result_next = op_if.operand_a.w ^ op_if.operand_b.w;
      ALU_ADD, ALU_SUB:
        result_next = sum_i;
      ALU_SLL, ALU_SRL, ALU_SRA, ALU_ROR:
        result_next = shift_i;
      // set-style ops give the flag in bit 0
      ALU_EQ, ALU_NE, ALU_SLTS, ALU_SLTU:
        result_next = {{(WORD_WIDTH-1){1'b0}}, cmp_flag_i};
      ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU, ALU_ABS:
        result_next = minmax_i;
      default:  result_next = '0;
    endcase
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////

  assign out_fire   = out_valid_o & out_ready_i;
  // room when empty or when the held result leaves this cycle
  assign in_ready_o = ~out_valid_o | out_ready_i;
  assign in_fire    = in_valid_i & in_ready_o;

  always_ff @(posedge clk)
  begin
    if (rst_i)
      out_valid_o <= 1'b0;
    else if (in_fire)
      out_valid_o <= 1'b1;
    else if (out_fire)
      out_valid_o <= 1'b0;
  end

  // payload only moves on accept, so it holds under a stall
  always_ff @(posedge clk)
  begin
    if (in_fire)
    begin
      result_o            <= result_next;
      comparison_result_o <= cmp_flag_i;
    end
  end

endmodule

// File: alu/simd_alu.sv
// top level of the SIMD integer ALU
// plain ports, operation bundle and the datapath units
// adder, shifter, compare unit and registered result stage

`timescale 1ns/1ps

module simd_alu import alu_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_i,
  // input side
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  logic [ALU_OP_WIDTH-1:0]   operator_i,
  input  logic [WORD_WIDTH-1:0]     operand_a_i,
  input  logic [WORD_WIDTH-1:0]     operand_b_i,
  input  logic [VEC_MODE_WIDTH-1:0] vector_mode_i,
  // output side
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output logic [WORD_WIDTH-1:0]     result_o,
  output logic                      comparison_result_o
);

  alu_word_u sum_word;
  alu_word_u shift_word;
  alu_word_u minmax_word;
  alu_word_u result_word;
  logic      cmp_flag;

  alu_op_if op_if ();

  // operation bundle fed straight from the ports
  assign op_if.operator  = operator_i;
  assign op_if.operand_a = operand_a_i;
  assign op_if.operand_b = operand_b_i;
  assign op_if.vec_mode  = vector_mode_i;

  alu_adder adder_inst (
    .op_if (op_if),
    .sum_o (sum_word)
  );

  alu_shifter shifter_inst (
    .op_if   (op_if),
    .shift_o (shift_word)
  );

  alu_compare compare_inst (
    .op_if      (op_if),
    .sum_i      (sum_word),
    .minmax_o   (minmax_word),
    .cmp_flag_o (cmp_flag)
  );

  alu_result_stage result_stage_inst (
    .clk                 (clk),
    .rst_i               (rst_i),
    .op_if               (op_if),
    .in_valid_i          (in_valid_i),
    .in_ready_o          (in_ready_o),
    .sum_i               (sum_word),
    .shift_i             (shift_word),
    .minmax_i            (minmax_word),
    .cmp_flag_i          (cmp_flag),
    .result_o            (result_word),
    .comparison_result_o (comparison_result_o),
    .out_valid_o         (out_valid_o),
    .out_ready_i         (out_ready_i)
  );

  assign result_o = result_word.w;

endmodule

// File: common/alu_op_if.sv
// operation bundle of the SIMD ALU
// operator, both operands and the vector mode
// with a source side and a read-only unit side

`timescale 1ns/1ps

interface alu_op_if import alu_pkg::*; ();

  logic [ALU_OP_WIDTH-1:0]   operator;
  alu_word_u                 operand_a;
  alu_word_u                 operand_b;
  logic [VEC_MODE_WIDTH-1:0] vec_mode;

  // driven from the top level input ports
  modport source (
    output operator, operand_a, operand_b, vec_mode
  );

  // read by the datapath units
  modport unit (
    input  operator, operand_a, operand_b, vec_mode
  );

endinterface

// File: common/alu_pkg.sv
// shared definitions of the SIMD integer ALU
// word and lane widths, operator codes, vector-mode codes
// and the lane word union used across the datapath

package alu_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // operand width and number of byte lanes in a word
  localparam int WORD_WIDTH     = 32;
  localparam int NUM_BYTES      = 4;

  // code widths
  localparam int ALU_OP_WIDTH   = 5;
  localparam int VEC_MODE_WIDTH = 2;

  ////////////////////////////////////////
  // vector modes
  ////////////////////////////////////////

  // one 32-bit lane, two 16-bit lanes, four 8-bit lanes
  localparam logic [VEC_MODE_WIDTH-1:0] VEC_MODE32 = 2'b00;
  localparam logic [VEC_MODE_WIDTH-1:0] VEC_MODE16 = 2'b10;
  localparam logic [VEC_MODE_WIDTH-1:0] VEC_MODE8  = 2'b11;

  ////////////////////////////////////////
  // operator codes
  ////////////////////////////////////////

  // arithmetic
  localparam logic [ALU_OP_WIDTH-1:0] ALU_ADD  = 5'h00;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SUB  = 5'h01;
  // shifts and rotate
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SLL  = 5'h02;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SRL  = 5'h03;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SRA  = 5'h04;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_ROR  = 5'h05;
  // bitwise logic
  localparam logic [ALU_OP_WIDTH-1:0] ALU_AND  = 5'h06;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_OR   = 5'h07;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_XOR  = 5'h08;
  // comparisons, result is the top lane flag
  localparam logic [ALU_OP_WIDTH-1:0] ALU_EQ   = 5'h09;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_NE   = 5'h0a;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SLTS = 5'h0b;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SLTU = 5'h0c;
  // lane-wise min, max and abs
  localparam logic [ALU_OP_WIDTH-1:0] ALU_MIN  = 5'h0d;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_MINU = 5'h0e;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_MAX  = 5'h0f;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_MAXU = 5'h10;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_ABS  = 5'h11;

  ////////////////////////////////////////
  // lane word
  ////////////////////////////////////////

  // one operand word seen as a whole, as halves or as bytes
  typedef union packed {
    logic [WORD_WIDTH-1:0]          w;
    logic [1:0][WORD_WIDTH/2-1:0]   h;
    logic [NUM_BYTES-1:0][7:0]      b;
  } alu_word_u;

endpackage

// File: logic/alu_adder.sv
// partitioned adder of the SIMD ALU
// add, subtract and per-lane negation for abs
// carry chain cut at lane boundaries by vector mode

`timescale 1ns/1ps

module alu_adder import alu_pkg::*; (
  alu_op_if.unit    op_if,
  output alu_word_u sum_o
);

  // one separator bit below each byte
  localparam int EXT_WIDTH = WORD_WIDTH + NUM_BYTES;

  logic                 do_sub;
  logic                 do_abs;
  logic                 carry_in;
  logic [NUM_BYTES-1:0] lane_start;
  alu_word_u            add_a;
  alu_word_u            add_b;
  logic [EXT_WIDTH-1:0] in_a;
  logic [EXT_WIDTH-1:0] in_b;
  logic [EXT_WIDTH-1:0] sum_ext;

  assign do_sub   = (op_if.operator == ALU_SUB);
  assign do_abs   = (op_if.operator == ALU_ABS);
  // two's complement needs a one into every lane
  assign carry_in = do_sub | do_abs;

  // abs is 0 - a, i.e. ~a + 0 + 1
  assign add_a = do_abs ? ~op_if.operand_a.w : op_if.operand_a.w;
  assign add_b = do_abs ? '0 : (do_sub ? ~op_if.operand_b.w : op_if.operand_b.w);

  // bytes that open a new lane
  always_comb
  begin
    lane_start    = '0;
    lane_start[0] = 1'b1;
    case (op_if.vec_mode)
      VEC_MODE16: lane_start[2] = 1'b1;
      VEC_MODE8:  lane_start    = '1;
      default:    ;
    endcase
  end

  ////////////////////////////////////////
  // separator insertion
  ////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < NUM_BYTES; i++)
    begin
      // 1+0 passes the carry on, c+c forces the lane carry-in to c
      in_a[9*i]        = lane_start[i] ? carry_in : 1'b1;
      in_b[9*i]        = lane_start[i] ? carry_in : 1'b0;
      in_a[9*i+8 -: 8] = add_a.b[i];
      in_b[9*i+8 -: 8] = add_b.b[i];
    end
  end

  // single wide adder
  assign sum_ext = in_a + in_b;

  // drop the separator bits again
  always_comb
  begin
    for (int i = 0; i < NUM_BYTES; i++)
    begin
      sum_o.b[i] = sum_ext[9*i+8 -: 8];
    end
  end

endmodule

// File: logic/alu_compare.sv
// comparison unit of the SIMD ALU
// per-byte equal and greater, combined into lanes by vector mode
// top lane flag for EQ, NE, SLTS, SLTU and the min/max/abs select

`timescale 1ns/1ps

module alu_compare import alu_pkg::*; (
  alu_op_if.unit    op_if,
  input  alu_word_u sum_i,
  output alu_word_u minmax_o,
  output logic      cmp_flag_o
);

  logic                 signed_op;
  logic                 do_min;
  logic [NUM_BYTES-1:0] cmp_signed;
  logic [NUM_BYTES-1:0] eq_byte;
  logic [NUM_BYTES-1:0] gt_byte;
  logic [NUM_BYTES-1:0] is_equal;
  logic [NUM_BYTES-1:0] is_greater;
  logic [NUM_BYTES-1:0] cmp_result;
  logic [NUM_BYTES-1:0] sel_a;
  alu_word_u            minmax_b;

  assign signed_op = (op_if.operator == ALU_SLTS) || (op_if.operator == ALU_MIN) ||
                     (op_if.operator == ALU_MAX)  || (op_if.operator == ALU_ABS);
  assign do_min    = (op_if.operator == ALU_MIN)  || (op_if.operator == ALU_MINU);

  // sign only counts in the top byte of each lane
  always_comb
  begin
    case (op_if.vec_mode)
      VEC_MODE8:  cmp_signed = {4{signed_op}};
      VEC_MODE16: cmp_signed = {signed_op, 1'b0, signed_op, 1'b0};
      default:    cmp_signed = {signed_op, 3'b000};
    endcase
  end

  ////////////////////////////////////////
  // byte compares
  ////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < NUM_BYTES; i++)
    begin
      eq_byte[i] = (op_if.operand_a.b[i] == op_if.operand_b.b[i]);
      // 9-bit signed compare, extra bit is the sign or zero
      gt_byte[i] = $signed({op_if.operand_a.b[i][7] & cmp_signed[i], op_if.operand_a.b[i]}) >
                   $signed({op_if.operand_b.b[i][7] & cmp_signed[i], op_if.operand_b.b[i]});
    end
  end

  // lane results, replicated over every byte of the lane
  always_comb
  begin
    case (op_if.vec_mode)
      VEC_MODE8:
      begin
        is_equal   = eq_byte;
        is_greater = gt_byte;
      end
      VEC_MODE16:
      begin
        is_equal[1:0]   = {2{eq_byte[1] & eq_byte[0]}};
        is_equal[3:2]   = {2{eq_byte[3] & eq_byte[2]}};
        is_greater[1:0] = {2{gt_byte[1] | (eq_byte[1] & gt_byte[0])}};
        is_greater[3:2] = {2{gt_byte[3] | (eq_byte[3] & gt_byte[2])}};
      end
      default:
      begin
        // most significant differing byte decides
        is_equal   = {4{&eq_byte}};
        is_greater = {4{gt_byte[3] | (eq_byte[3] & (gt_byte[2] |
                        (eq_byte[2] & (gt_byte[1] | (eq_byte[1] & gt_byte[0])))))}};
      end
    endcase
  end

  // a < b is neither greater nor equal
  always_comb
  begin
    case (op_if.operator)
      ALU_NE:             cmp_result = ~is_equal;
      ALU_SLTS, ALU_SLTU: cmp_result = ~(is_greater | is_equal);
      default:            cmp_result = is_equal;
    endcase
  end

  assign cmp_flag_o = cmp_result[NUM_BYTES-1];

  ////////////////////////////////////////
  // min / max / abs select
  ////////////////////////////////////////

  // abs picks between a and its negation from the adder
  assign minmax_b = (op_if.operator == ALU_ABS) ? sum_i : op_if.operand_b;
  assign sel_a    = is_greater ^ {NUM_BYTES{do_min}};

  always_comb
  begin
    for (int i = 0; i < NUM_BYTES; i++)
    begin
      minmax_o.b[i] = sel_a[i] ? op_if.operand_a.b[i] : minmax_b.b[i];
    end
  end

endmodule

// File: logic/alu_shifter.sv
// lane-wise shifter of the SIMD ALU
// logical and arithmetic right shifts per lane
// left shifts through bit reversal, 32-bit rotate right

`timescale 1ns/1ps

module alu_shifter import alu_pkg::*; (
  alu_op_if.unit    op_if,
  output alu_word_u shift_o
);

  logic                    shift_left;
  logic                    shift_arith;
  alu_word_u               amt_left;
  alu_word_u               shift_amt;
  alu_word_u               src;
  alu_word_u               shr;
  logic [2*WORD_WIDTH-1:0] rot;

  // mirror a whole word
  function automatic logic [WORD_WIDTH-1:0] bit_rev(input logic [WORD_WIDTH-1:0] x);
    logic [WORD_WIDTH-1:0] r;
    for (int i = 0; i < WORD_WIDTH; i++)
    begin
      r[i] = x[WORD_WIDTH-1-i];
    end
    return r;
  endfunction

  assign shift_left  = (op_if.operator == ALU_SLL);
  assign shift_arith = (op_if.operator == ALU_SRA);

  ////////////////////////////////////////
  // operand and amount preparation
  ////////////////////////////////////////

  // mirrored word puts lane k where lane N-1-k was, so the amounts follow
  always_comb
  begin
    amt_left = op_if.operand_b;
    case (op_if.vec_mode)
      VEC_MODE16:
      begin
        amt_left.h[0] = op_if.operand_b.h[1];
        amt_left.h[1] = op_if.operand_b.h[0];
      end
      VEC_MODE8:
      begin
        for (int k = 0; k < NUM_BYTES; k++)
        begin
          amt_left.b[k] = op_if.operand_b.b[NUM_BYTES-1-k];
        end
      end
      default: ;
    endcase
  end

  assign shift_amt = shift_left ? amt_left : op_if.operand_b;
  assign src       = shift_left ? bit_rev(op_if.operand_a.w) : op_if.operand_a.w;

  // rotate reads the bits that fall out of the low end from the copy above
  assign rot = {src.w, src.w} >> shift_amt.w[4:0];

  ////////////////////////////////////////
  // right shift per lane
  ////////////////////////////////////////

  always_comb
  begin
    shr = src;
    case (op_if.vec_mode)
      VEC_MODE16:
      begin
        for (int k = 0; k < 2; k++)
        begin
          if (shift_arith)
            shr.h[k] = $unsigned($signed(src.h[k]) >>> shift_amt.h[k][3:0]);
          else
            shr.h[k] = src.h[k] >> shift_amt.h[k][3:0];
        end
      end
      VEC_MODE8:
      begin
        for (int k = 0; k < NUM_BYTES; k++)
        begin
          if (shift_arith)
            shr.b[k] = $unsigned($signed(src.b[k]) >>> shift_amt.b[k][2:0]);
          else
            shr.b[k] = src.b[k] >> shift_amt.b[k][2:0];
        end
      end
      default:
      begin
        // single 32-bit lane, only mode with rotate
        if (shift_arith)
          shr.w = $unsigned($signed(src.w) >>> shift_amt.w[4:0]);
        else if (op_if.operator == ALU_ROR)
          shr.w = rot[WORD_WIDTH-1:0];
        else
          shr.w = src.w >> shift_amt.w[4:0];
      end
    endcase
  end

  // undo the mirroring for left shifts
  assign shift_o = shift_left ? bit_rev(shr.w) : shr.w;

endmodule

// File: src.f
common/alu_pkg.sv
common/alu_op_if.sv
logic/alu_adder.sv
logic/alu_shifter.sv
logic/alu_compare.sv
alu/alu_result_stage.sv
alu/simd_alu.sv
verification/simd_alu_assert.sv
verification/simd_alu_tb.sv

// File: verification/simd_alu_assert.sv
// handshake and reset assertions of the SIMD ALU
// empty register after reset, hold under stall,
// in_ready_o rule and one-cycle latency of an accepted transfer

`timescale 1ns/1ps

module simd_alu_assert import alu_pkg::*; (
  input logic                  clk,
  input logic                  rst_i,
  input logic                  in_valid_i,
  input logic                  in_ready_o,
  input logic                  out_valid_o,
  input logic                  out_ready_i,
  input logic [WORD_WIDTH-1:0] result_o,
  input logic                  comparison_result_o
);

  // register is empty once reset has been seen
  valid_low_after_reset: assert property (
    @(posedge clk) rst_i |=> !out_valid_o
  ) else $error("out_valid_o high in the cycle after reset");

  // a stalled result stays put until it leaves
  hold_under_stall: assert property (
    @(posedge clk) disable iff (rst_i)
      (out_valid_o && !out_ready_i) |=>
        (out_valid_o && $stable(result_o) && $stable(comparison_result_o))
  ) else $error("output valid or payload changed under stall");

  // room when empty or when the held result leaves
  ready_rule: assert property (
    @(posedge clk) disable iff (rst_i)
      in_ready_o == (!out_valid_o || out_ready_i)
  ) else $error("in_ready_o does not follow out_valid_o and out_ready_i");

  // fixed latency of one cycle
  result_after_accept: assert property (
    @(posedge clk) disable iff (rst_i)
      (in_valid_i && in_ready_o) |=> out_valid_o
  ) else $error("no valid result one cycle after an accepted transfer");

endmodule

bind simd_alu simd_alu_assert simd_alu_assert_inst (
  .clk                 (clk),
  .rst_i               (rst_i),
  .in_valid_i          (in_valid_i),
  .in_ready_o          (in_ready_o),
  .out_valid_o         (out_valid_o),
  .out_ready_i         (out_ready_i),
  .result_o            (result_o),
  .comparison_result_o (comparison_result_o)
);

// File: verification/simd_alu_tb.sv
// testbench of the SIMD integer ALU
// random operations and back-pressure from a fixed seed
// lane model with a queue of expected results
// typed compare tasks, handshake checks, timeout, closing result line

`timescale 1ns/1ps

module simd_alu_tb import alu_pkg::*; ();

  localparam int CLK_PERIOD     = 40;
  localparam int RESET_CYCLES   = 5;
  localparam int NUM_TRANSFERS  = 400;
  localparam int TIMEOUT_CYCLES = 4 * NUM_TRANSFERS + 100;
  localparam int NUM_OPS        = 18;

  logic                      clk;
  logic                      rst_i;
  logic                      in_valid_i;
  logic                      in_ready_o;
  logic [ALU_OP_WIDTH-1:0]   operator_i;
  alu_word_u                 operand_a_i;
  alu_word_u                 operand_b_i;
  logic [VEC_MODE_WIDTH-1:0] vector_mode_i;
  logic                      out_valid_o;
  logic                      out_ready_i;
  alu_word_u                 result_o;
  logic                      comparison_result_o;

  integer seed;
  int     cycle_count;
  int     sent;
  int     received;
  int     word_errors;
  int     flag_errors;
  int     protocol_errors;

  // expected results in acceptance order
  alu_word_u exp_word_q[$];
  logic      exp_flag_q[$];
  logic      exp_cmp_q[$];
  string     name_q[$];

  // indexed by operator code
  string op_names [NUM_OPS] = '{"ADD", "SUB", "SLL", "SRL", "SRA", "ROR", "AND", "OR", "XOR",
                                "EQ", "NE", "SLTS", "SLTU", "MIN", "MINU", "MAX", "MAXU", "ABS"};

  simd_alu simd_alu_inst (
    .clk                 (clk),
    .rst_i               (rst_i),
    .in_valid_i          (in_valid_i),
    .in_ready_o          (in_ready_o),
    .operator_i          (operator_i),
    .operand_a_i         (operand_a_i),
    .operand_b_i         (operand_b_i),
    .vector_mode_i       (vector_mode_i),
    .out_valid_o         (out_valid_o),
    .out_ready_i         (out_ready_i),
    .result_o            (result_o),
    .comparison_result_o (comparison_result_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic int lane_width(input logic [VEC_MODE_WIDTH-1:0] mode);
    case (mode)
      VEC_MODE16: return 16;
      VEC_MODE8:  return 8;
      default:    return 32;
    endcase
  endfunction

  function automatic logic [WORD_WIDTH-1:0] lane_mask(input int lw);
    return (lw == WORD_WIDTH) ? 32'hffff_ffff : ((32'h1 << lw) - 32'h1);
  endfunction

  // lane k of a word moved down to bit 0
  function automatic logic [WORD_WIDTH-1:0] lane_of(input alu_word_u x, input int k, input int lw);
    return (x.w >> (k * lw)) & lane_mask(lw);
  endfunction

  // sign taken from bit lw-1
  function automatic logic signed [WORD_WIDTH-1:0] sign_ext(input logic [WORD_WIDTH-1:0] v,
                                                            input int lw);
    logic [WORD_WIDTH-1:0] t;
    t = v << (WORD_WIDTH - lw);
    return $signed(t) >>> (WORD_WIDTH - lw);
  endfunction

  function automatic logic is_compare(input logic [ALU_OP_WIDTH-1:0] op);
    return (op == ALU_EQ) || (op == ALU_NE) || (op == ALU_SLTS) || (op == ALU_SLTU);
  endfunction

  // result of one lane before the caller masks the upper bits
  function automatic logic [WORD_WIDTH-1:0] model_lane(input logic [ALU_OP_WIDTH-1:0] op,
                                                       input logic [WORD_WIDTH-1:0] la,
                                                       input logic [WORD_WIDTH-1:0] lb,
                                                       input int lw);
    int                           amt;
    logic signed [WORD_WIDTH-1:0] sa;
    logic signed [WORD_WIDTH-1:0] sb;
    amt = lb & (lw - 1);
    sa  = sign_ext(la, lw);
    sb  = sign_ext(lb, lw);
    case (op)
      ALU_ADD:  return la + lb;
      ALU_SUB:  return la - lb;
      ALU_SLL:  return la << amt;
      ALU_SRL:  return la >> amt;
      ALU_SRA:  return sa >>> amt;
      ALU_ROR:  return (la >> amt) | (la << (lw - amt));
      ALU_AND:  return la & lb;
      ALU_OR:   return la | lb;
      ALU_XOR:  return la ^ lb;
      ALU_MIN:  return (sa < sb) ? la : lb;
      ALU_MINU: return (la < lb) ? la : lb;
      ALU_MAX:  return (sa > sb) ? la : lb;
      ALU_MAXU: return (la > lb) ? la : lb;
      // keep a where a > b signed, negate otherwise
      ALU_ABS:  return (sa > sb) ? la : -la;
      default:  return '0;
    endcase
  endfunction

  // comparisons look at the top lane only
  function automatic logic model_flag(input logic [ALU_OP_WIDTH-1:0] op, input alu_word_u a,
                                      input alu_word_u b, input logic [VEC_MODE_WIDTH-1:0] mode);
    int                    lw;
    logic [WORD_WIDTH-1:0] la;
    logic [WORD_WIDTH-1:0] lb;
    lw = lane_width(mode);
    la = lane_of(a, WORD_WIDTH / lw - 1, lw);
    lb = lane_of(b, WORD_WIDTH / lw - 1, lw);
    case (op)
      ALU_EQ:   return la == lb;
      ALU_NE:   return la != lb;
      ALU_SLTS: return sign_ext(la, lw) < sign_ext(lb, lw);
      ALU_SLTU: return la < lb;
      default:  return 1'b0;
    endcase
  endfunction

  function automatic alu_word_u model_word(input logic [ALU_OP_WIDTH-1:0] op, input alu_word_u a,
                                           input alu_word_u b,
                                           input logic [VEC_MODE_WIDTH-1:0] mode);
    alu_word_u r;
    int        lw;
    lw  = lane_width(mode);
    r.w = '0;
    if (is_compare(op))
      r.w[0] = model_flag(op, a, b, mode);
    else
      for (int k = 0; k < WORD_WIDTH / lw; k++)
        r.w = r.w | ((model_lane(op, lane_of(a, k, lw), lane_of(b, k, lw), lw)
                      & lane_mask(lw)) << (k * lw));
    return r;
  endfunction

  ////////////////////////////////////////
  // checks and stimulus
  ////////////////////////////////////////

  task automatic check_word(input string name, input alu_word_u expected, input alu_word_u actual);
    if (actual.w !== expected.w)
    begin
      word_errors++;
      $display("Mismatch %s: expected %h, actual %h", name, expected.w, actual.w);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      flag_errors++;
      $display("Mismatch %s flag: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic report_protocol_error(input string what);
    protocol_errors++;
    $display("handshake error in cycle %0d: %s", cycle_count, what);
  endtask

  // every operator in turn with random operands and mode
  task automatic load_next_item();
    int sel;
    operator_i    = ALU_OP_WIDTH'(sent % NUM_OPS);
    operand_a_i.w = $random(seed);
    operand_b_i.w = $random(seed);
    sel           = $unsigned($random(seed)) % 4;
    // equal words and equal top halves give the comparisons their equal cases
    if (sel == 0)
      operand_b_i.w = operand_a_i.w;
    else if (sel == 1)
      operand_b_i.h[1] = operand_a_i.h[1];
    case ($unsigned($random(seed)) % 3)
      0:       vector_mode_i = VEC_MODE32;
      1:       vector_mode_i = VEC_MODE16;
      default: vector_mode_i = VEC_MODE8;
    endcase
    // rotate exists for the single lane only
    if (operator_i == ALU_ROR)
      vector_mode_i = VEC_MODE32;
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial
  begin : stimulus
    logic      offering;
    logic      in_fire;
    logic      out_fire;
    logic      prev_in_fire;
    logic      prev_stall;
    logic      prev_flag;
    logic      exp_flag;
    logic      exp_cmp;
    alu_word_u prev_result;
    alu_word_u exp_word;
    string     name;
    seed            = 65;
    sent            = 0;
    received        = 0;
    word_errors     = 0;
    flag_errors     = 0;
    protocol_errors = 0;
    offering        = 1'b0;
    prev_in_fire    = 1'b0;
    prev_stall      = 1'b0;
    prev_flag       = 1'b0;
    prev_result     = '0;
    rst_i           = 1'b1;
    in_valid_i      = 1'b0;
    out_ready_i     = 1'b0;
    operator_i      = ALU_ADD;
    operand_a_i     = '0;
    operand_b_i     = '0;
    vector_mode_i   = VEC_MODE32;
    // reset held over five rising edges, released on a falling edge
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    #1;
    if (out_valid_o !== 1'b0)
      report_protocol_error("out_valid_o is not low after reset");
    if (in_ready_o !== 1'b1)
      report_protocol_error("in_ready_o is not high after reset");
    while (received < NUM_TRANSFERS)
    begin
      @(negedge clk);
      // a new item only once the offered one was taken
      if (!offering && sent < NUM_TRANSFERS && ($unsigned($random(seed)) % 4 != 0))
      begin
        load_next_item();
        offering = 1'b1;
      end
      in_valid_i  = offering;
      out_ready_i = ($unsigned($random(seed)) % 4 != 0);
      #1;
      // outputs seen here were set by the last rising edge
      if (prev_in_fire && out_valid_o !== 1'b1)
        report_protocol_error("no valid result one cycle after an accepted transfer");
      if (prev_stall && (out_valid_o !== 1'b1 || result_o.w !== prev_result.w ||
                         comparison_result_o !== prev_flag))
        report_protocol_error("output changed while the sink was stalled");
      if (out_valid_o !== (exp_word_q.size() != 0))
        report_protocol_error("out_valid_o disagrees with the number of pending transfers");
      if (in_ready_o !== (!out_valid_o || out_ready_i))
        report_protocol_error("in_ready_o does not follow out_valid_o and out_ready_i");
      // what the next rising edge will do
      out_fire = out_valid_o && out_ready_i;
      in_fire  = in_valid_i && in_ready_o;
      if (out_fire && exp_word_q.size() != 0)
      begin
        name     = name_q.pop_front();
        exp_word = exp_word_q.pop_front();
        exp_flag = exp_flag_q.pop_front();
        exp_cmp  = exp_cmp_q.pop_front();
        check_word(name, exp_word, result_o);
        if (exp_cmp)
          check_flag(name, exp_flag, comparison_result_o);
        received++;
      end
      if (in_fire)
      begin
        name_q.push_back($sformatf("%s %0d-bit #%0d", op_names[operator_i],
                                   lane_width(vector_mode_i), sent));
        exp_word_q.push_back(model_word(operator_i, operand_a_i, operand_b_i, vector_mode_i));
        exp_flag_q.push_back(model_flag(operator_i, operand_a_i, operand_b_i, vector_mode_i));
        exp_cmp_q.push_back(is_compare(operator_i));
        sent++;
        offering = 1'b0;
      end
      prev_in_fire = in_fire;
      prev_stall   = out_valid_o && !out_ready_i;
      prev_result  = result_o;
      prev_flag    = comparison_result_o;
    end
    $display("errors: %0d result, %0d flag, %0d handshake over %0d transfers",
             word_errors, flag_errors, protocol_errors, received);
    if (word_errors + flag_errors + protocol_errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  // run limit from the transfer count
  initial
  begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles with %0d of %0d results received",
             cycle_count, received, NUM_TRANSFERS);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
